/* src/dll_pkg.sv */
package dll_pkg;

   // Correlator magnitude and intermediate widths
   localparam int IQ_WIDTH    = 16;
   localparam int PRE_WIDTH   = 17;
   localparam int OP_WIDTH    = 10;
   localparam int INDEX_WIDTH = 5;
   localparam int SCALE_WIDTH = 12;
   // Product of OP_WIDTH and SCALE_WIDTH, also numerator and quotient width
   localparam int PROD_WIDTH  = 22;

   // Fixed-point scale, dphi = ((eml * K) / epl) >> SCALE_SHIFT
   localparam logic [SCALE_WIDTH-1:0] SCALE_K = 12'd3000;
   localparam int SCALE_SHIFT = 4;

   // Correction, channel and rate definitions
   localparam int DPHI_WIDTH = 16;
   localparam int CHAN_WIDTH = 3;
   localparam int NUM_CHAN   = 8;
   localparam int RATE_WIDTH = 32;
   localparam logic [RATE_WIDTH-1:0] NOMINAL_RATE = 32'h0100_0000;

   // Strobe to strobe latencies in clk cycles
   localparam int DISC_LATENCY   = 27;
   localparam int FILTER_LATENCY = 1;

   // Request from a correlator
   typedef struct packed {
      logic [CHAN_WIDTH-1:0] tag;
      logic [IQ_WIDTH-1:0]   early;
      logic [IQ_WIDTH-1:0]   late;
   } dll_req_t;

   // Signed code phase increment correction
   typedef struct packed {
      logic [CHAN_WIDTH-1:0]        tag;
      logic signed [DPHI_WIDTH-1:0] dphi;
   } dll_disc_t;

   // Updated per-channel code rate
   typedef struct packed {
      logic [CHAN_WIDTH-1:0] tag;
      logic [RATE_WIDTH-1:0] rate;
   } dll_rate_t;

endpackage

/* src/dll_operand_norm.sv */
`timescale 1ns/10ps

module dll_operand_norm (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [dll_pkg::PRE_WIDTH-1:0] sum,
   input  logic [dll_pkg::PRE_WIDTH-1:0] diff,
   output logic [dll_pkg::OP_WIDTH-1:0]  sum_t,
   output logic [dll_pkg::OP_WIDTH-1:0]  diff_t
);
   import dll_pkg::*;

   // Position of the highest set bit, 0 for an all-zero word
   function automatic logic [INDEX_WIDTH-1:0] lead_one(input logic [PRE_WIDTH-1:0] w);
      logic [INDEX_WIDTH-1:0] idx;
      idx = '0;
      // Later hits overwrite earlier ones so the top bit wins
      for (int b = 0; b < PRE_WIDTH; b++) begin
         if (w[b]) begin
            idx = b[INDEX_WIDTH-1:0];
         end
      end
      return idx;
   endfunction

   // Window of OP_WIDTH bits ending at idx
   function automatic logic [OP_WIDTH-1:0] window(input logic [PRE_WIDTH-1:0] w,
                                                  input logic [INDEX_WIDTH-1:0] idx);
      logic [PRE_WIDTH-1:0] shifted;
      // Small values already fit, keep them unchanged
      if (idx < INDEX_WIDTH'(OP_WIDTH - 1)) begin
         shifted = w;
      end else begin
         shifted = w >> (idx - INDEX_WIDTH'(OP_WIDTH - 1));
      end
      return shifted[OP_WIDTH-1:0];
   endfunction

   logic [INDEX_WIDTH-1:0] idx_q;
   logic [PRE_WIDTH-1:0]   sum_q;
   logic [PRE_WIDTH-1:0]   diff_q;

   // Stage 1, leading one of sum
   // |e-l| never exceeds e+l so sum alone sets the window
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx_q <= '0;
      end else begin
         idx_q <= lead_one(sum);
      end
   end

   // Operands ride alongside the index so a pair can enter every cycle
   always_ff @(posedge clk) begin
      sum_q  <= sum;
      diff_q <= diff;
   end

   // Stage 2, both words cut with the same window
   // Keeps the ratio diff/sum roughly intact
   always_ff @(posedge clk) begin
      sum_t  <= window(sum_q, idx_q);
      diff_t <= window(diff_q, idx_q);
   end

endmodule

/* src/dll_divider.sv */
`timescale 1ns/10ps

module dll_divider (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [dll_pkg::PROD_WIDTH-1:0] numer,
   input  logic [dll_pkg::OP_WIDTH-1:0]   denom,
   output logic [dll_pkg::PROD_WIDTH-1:0] quo
);
   import dll_pkg::*;

   // Per stage state
   // rem_q holds the partial remainder, always below the denominator
   // nq_q shifts numerator bits out at the top and quotient bits in at the bottom
   logic [OP_WIDTH-1:0]   rem_q  [PROD_WIDTH];
   logic [PROD_WIDTH-1:0] nq_q   [PROD_WIDTH];
   logic [OP_WIDTH-1:0]   den_q  [PROD_WIDTH];
   logic                  zero_q [PROD_WIDTH];

   for (genvar s = 0; s < PROD_WIDTH; s++) begin : g_stage
      logic [OP_WIDTH-1:0]   rem_in;
      logic [PROD_WIDTH-1:0] nq_in;
      logic [OP_WIDTH-1:0]   den_in;
      logic                  zero_in;
      logic [OP_WIDTH:0]     trial;
      logic [OP_WIDTH:0]     sub;
      logic                  q_bit;

      if (s == 0) begin : g_first
         // Fresh division, empty remainder
         assign rem_in  = '0;
         assign nq_in   = numer;
         assign den_in  = denom;
         assign zero_in = (denom == '0);
      end else begin : g_next
         assign rem_in  = rem_q[s-1];
         assign nq_in   = nq_q[s-1];
         assign den_in  = den_q[s-1];
         assign zero_in = zero_q[s-1];
      end

      // Bring down the next numerator bit and try a subtract
      assign trial = {rem_in, nq_in[PROD_WIDTH-1]};
      assign sub   = trial - {1'b0, den_in};
      assign q_bit = (trial >= {1'b0, den_in});

      always_ff @(posedge clk) begin
         // Restore on failure, keep the difference on success
         rem_q[s] <= q_bit ? sub[OP_WIDTH-1:0] : trial[OP_WIDTH-1:0];
         nq_q[s]  <= {nq_in[PROD_WIDTH-2:0], q_bit};
         den_q[s] <= den_in;
      end

      // Divide-by-zero flag travels with its operands
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            zero_q[s] <= 1'b1;
         end else begin
            zero_q[s] <= zero_in;
         end
      end
   end

   // Zero denominator would give all ones, force zero instead
   assign quo = zero_q[PROD_WIDTH-1] ? '0 : nq_q[PROD_WIDTH-1];

endmodule

/* src/dll_discriminator.sv */
`timescale 1ns/10ps

module dll_discriminator (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  dll_pkg::dll_req_t  req,
   output logic               disc_valid,
   output dll_pkg::dll_disc_t disc
);
   import dll_pkg::*;

   // Code phase correction
   //   eml = early - late, epl = early + late
   //   dphi = sign(eml) * (((|eml| * K) / epl) >> SCALE_SHIFT)
   // Steps
   //   Register of sum, |diff| and sign
   //   Leading-one search and truncation in dll_operand_norm
   //   Multiply by K
   //   Pipelined divide, one stage per quotient bit
   //   Shift, sign applied at the output

   // Side-band data that follows each request down the pipe
   typedef struct packed {
      logic [CHAN_WIDTH-1:0] tag;
      logic                  sign;
   } meta_t;

   logic [PRE_WIDTH-1:0] early_ext;
   logic [PRE_WIDTH-1:0] late_ext;
   logic                 late_gt;

   logic [PRE_WIDTH-1:0]  sum_q;
   logic [PRE_WIDTH-1:0]  diff_q;
   logic [OP_WIDTH-1:0]   sum_t;
   logic [OP_WIDTH-1:0]   diff_t;
   logic [OP_WIDTH-1:0]   den_q;
   logic [PROD_WIDTH-1:0] prod_q;
   logic [PROD_WIDTH-1:0] quo;
   logic [DPHI_WIDTH-1:0] mag_q;

   logic  valid_pipe [DISC_LATENCY];
   meta_t meta_pipe  [DISC_LATENCY];
   meta_t meta_out;

   // Zero-extend so the sum cannot overflow
   assign early_ext = {{(PRE_WIDTH-IQ_WIDTH){1'b0}}, req.early};
   assign late_ext  = {{(PRE_WIDTH-IQ_WIDTH){1'b0}}, req.late};
   // Negative correction when late wins
   assign late_gt   = (req.late > req.early);

   // Stage 1 registers the sum and the magnitude of the difference
   always_ff @(posedge clk) begin
      sum_q  <= early_ext + late_ext;
      diff_q <= late_gt ? (late_ext - early_ext) : (early_ext - late_ext);
   end

   // Stages 2 and 3
   dll_operand_norm i_dll_operand_norm (
      .clk    (clk),
      .rst_n  (rst_n),
      .sum    (sum_q),
      .diff   (diff_q),
      .sum_t  (sum_t),
      .diff_t (diff_t)
   );

   // Stage 4 scales the difference
   // Denominator waits one cycle to stay beside its product
   always_ff @(posedge clk) begin
      prod_q <= PROD_WIDTH'(diff_t) * PROD_WIDTH'(SCALE_K);
      den_q  <= sum_t;
   end

   // Stages 5 to 26
   dll_divider i_dll_divider (
      .clk   (clk),
      .rst_n (rst_n),
      .numer (prod_q),
      .denom (den_q),
      .quo   (quo)
   );

   // Stage 27 drops the fixed-point fraction
   // Quotient never exceeds K so the result fits DPHI_WIDTH
   always_ff @(posedge clk) begin
      mag_q <= quo[DPHI_WIDTH+SCALE_SHIFT-1:SCALE_SHIFT];
   end

   // Strobe delay line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DISC_LATENCY; i++) begin
            valid_pipe[i] <= 1'b0;
         end
      end else begin
         valid_pipe[0] <= req_valid;
         for (int i = 1; i < DISC_LATENCY; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
         end
      end
   end

   // Tag and sign follow at the same depth
   always_ff @(posedge clk) begin
      meta_pipe[0] <= '{tag: req.tag, sign: late_gt};
      for (int i = 1; i < DISC_LATENCY; i++) begin
         meta_pipe[i] <= meta_pipe[i-1];
      end
   end

   assign meta_out = meta_pipe[DISC_LATENCY-1];

   // Sign applied on the registered magnitude
   assign disc_valid = valid_pipe[DISC_LATENCY-1];
   assign disc.tag   = meta_out.tag;
   assign disc.dphi  = meta_out.sign ? -mag_q : mag_q;

endmodule

/* src/dll_loop_filter.sv */
`timescale 1ns/10ps

module dll_loop_filter (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               disc_valid,
   input  dll_pkg::dll_disc_t disc,
   output logic               rate_valid,
   output dll_pkg::dll_rate_t rate
);
   import dll_pkg::*;

   // One code rate integrator per channel
   logic [RATE_WIDTH-1:0] rate_q [NUM_CHAN];
   logic [RATE_WIDTH-1:0] dphi_ext;
   logic [RATE_WIDTH-1:0] rate_next;

   // Sign-extend the correction to the rate width
   assign dphi_ext  = {{(RATE_WIDTH-DPHI_WIDTH){disc.dphi[DPHI_WIDTH-1]}}, disc.dphi};
   // Read of the addressed channel, already updated by a result one cycle earlier
   assign rate_next = rate_q[disc.tag] + dphi_ext;

   // Rates are loop state, all channels start at nominal
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            rate_q[c] <= NOMINAL_RATE;
         end
      end else if (disc_valid) begin
         rate_q[disc.tag] <= rate_next;
      end
   end

   // Update strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rate_valid <= 1'b0;
      end else begin
         rate_valid <= disc_valid;
      end
   end

   // Report the new value with its channel
   always_ff @(posedge clk) begin
      if (disc_valid) begin
         rate.tag  <= disc.tag;
         rate.rate <= rate_next;
      end
   end

endmodule

/* src/dll_tracker.sv */
`timescale 1ns/10ps

module dll_tracker (
   input  logic               clk,
   input  logic               rst_n,
   // Correlator request strobe
   input  logic               req_valid,
   input  dll_pkg::dll_req_t  req,
   // Correction, DISC_LATENCY cycles after the request
   output logic               disc_valid,
   output dll_pkg::dll_disc_t disc,
   // Updated rate, one cycle after the correction
   output logic               rate_valid,
   output dll_pkg::dll_rate_t rate
);

   // Code discriminator
   // No back-pressure, a request may arrive on every cycle
   dll_discriminator i_dll_discriminator (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .disc_valid (disc_valid),
      .disc       (disc)
   );

   // Loop filter
   // Sees the same strobe that leaves on the top-level port
   dll_loop_filter i_dll_loop_filter (
      .clk        (clk),
      .rst_n      (rst_n),
      .disc_valid (disc_valid),
      .disc       (disc),
      .rate_valid (rate_valid),
      .rate       (rate)
   );

endmodule

/* tb/dll_props.sv */
`timescale 1ns/10ps

module dll_props (
   input logic               clk,
   input logic               rst_n,
   input logic               req_valid,
   input logic               disc_valid,
   input dll_pkg::dll_disc_t disc,
   input logic               rate_valid,
   input dll_pkg::dll_rate_t rate
);
   import dll_pkg::*;

   // Request strobes of the last DISC_LATENCY cycles
   logic [DISC_LATENCY-1:0] req_hist;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_hist <= '0;
      end else begin
         req_hist <= {req_hist[DISC_LATENCY-2:0], req_valid};
      end
   end

   // Correction strobe is the request strobe, 27 cycles late
   disc_latency: assert property (@(posedge clk) disable iff (!rst_n)
      disc_valid == req_hist[DISC_LATENCY-1])
      else $error("disc_valid is not req_valid delayed by %0d cycles", DISC_LATENCY);

   // Rate update one cycle behind the correction
   rate_latency: assert property (@(posedge clk) disable iff (!rst_n)
      rate_valid == $past(disc_valid))
      else $error("rate_valid is not disc_valid delayed by one cycle");

   // Rate reports the channel of the previous correction
   rate_tag: assert property (@(posedge clk) disable iff (!rst_n)
      rate_valid |-> rate.tag == $past(disc.tag))
      else $error("rate tag differs from the previous disc tag");

   // Strobes are quiet under reset
   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> !disc_valid && !rate_valid)
      else $error("valid strobe seen while reset was asserted");

endmodule

/* tb/dll_tb.sv */
`timescale 1ns/10ps

module dll_tb;
   import dll_pkg::*;

   // Expected correction and the cycle in which the DUT samples its request
   typedef struct packed {
      logic [CHAN_WIDTH-1:0]        tag;
      logic signed [DPHI_WIDTH-1:0] dphi;
      logic [31:0]                  sent;
   } expect_t;

   logic      clk;
   logic      rst_n;
   logic      req_valid;
   dll_req_t  req;
   logic      disc_valid;
   dll_disc_t disc;
   logic      rate_valid;
   dll_rate_t rate;

   int unsigned           cycle = 0;
   int                    seed;
   int                    value_errors;
   int                    other_errors;
   expect_t               disc_q [$];
   dll_rate_t             rate_q [$];
   logic [RATE_WIDTH-1:0] model_rate [NUM_CHAN];

   dll_tracker i_dll_tracker (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .disc_valid (disc_valid),
      .disc       (disc),
      .rate_valid (rate_valid),
      .rate       (rate)
   );

   // Handshake and latency properties
   bind dll_tracker dll_props i_dll_props (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .disc_valid (disc_valid),
      .disc       (disc),
      .rate_valid (rate_valid),
      .rate       (rate)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Cycle count, read by both processes before it moves
   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // Expected dphi straight from the discriminator rule
   function automatic logic signed [DPHI_WIDTH-1:0] ref_dphi(input logic [IQ_WIDTH-1:0] early,
                                                           input logic [IQ_WIDTH-1:0] late);
      logic [PRE_WIDTH-1:0]         s;
      logic [PRE_WIDTH-1:0]         d;
      int                           top;
      int                           cut;
      logic [OP_WIDTH-1:0]          s_t;
      logic [OP_WIDTH-1:0]          d_t;
      longint                       num;
      longint                       mag;
      logic signed [DPHI_WIDTH-1:0] res;
      s = PRE_WIDTH'(early) + PRE_WIDTH'(late);
      if (late > early) begin
         d = PRE_WIDTH'(late) - PRE_WIDTH'(early);
      end else begin
         d = PRE_WIDTH'(early) - PRE_WIDTH'(late);
      end
      // Leading one of the sum picks the window for both words
      top = 0;
      for (int b = 0; b < PRE_WIDTH; b++) begin
         if (s[b]) begin
            top = b;
         end
      end
      cut = (top > OP_WIDTH - 1) ? top - (OP_WIDTH - 1) : 0;
      s_t = OP_WIDTH'(s >> cut);
      d_t = OP_WIDTH'(d >> cut);
      num = longint'(d_t) * longint'(SCALE_K);
      // Zero sum means no correction
      if (s_t == '0) begin
         mag = '0;
      end else begin
         mag = (num / longint'(s_t)) >>> SCALE_SHIFT;
      end
      res = DPHI_WIDTH'(mag);
      if (late > early) begin
         res = -res;
      end
      return res;
   endfunction

   task automatic check_value(input string what, input longint got, input longint exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // One request strobe, expectation queued alongside
   task automatic send_req(input logic [CHAN_WIDTH-1:0] tag,
                           input logic [IQ_WIDTH-1:0]   early,
                           input logic [IQ_WIDTH-1:0]   late);
      expect_t e;
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= '{tag: tag, early: early, late: late};
      e.tag  = tag;
      e.dphi = ref_dphi(early, late);
      // DUT samples on the next edge
      e.sent = cycle + 1;
      disc_q.push_back(e);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   // Scoreboard, samples on the falling edge where outputs are stable
   initial begin : compare
      expect_t               e;
      dll_rate_t             r;
      logic [RATE_WIDTH-1:0] next_rate;
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (rate_valid) begin
               if (rate_q.size() == 0) begin
                  other_errors++;
                  $display("Unexpected rate_valid strobe at time %0t", $time);
               end else begin
                  r = rate_q.pop_front();
                  check_value("rate tag", longint'(rate.tag), longint'(r.tag));
                  check_value("rate value", longint'(rate.rate), longint'(r.rate));
               end
            end
            if (disc_valid) begin
               if (disc_q.size() == 0) begin
                  other_errors++;
                  $display("Unexpected disc_valid strobe at time %0t", $time);
               end else begin
                  e = disc_q.pop_front();
                  check_value("disc tag", longint'(disc.tag), longint'(e.tag));
                  check_value("disc dphi", longint'(disc.dphi), longint'(e.dphi));
                  check_value("disc latency", longint'(cycle - e.sent), longint'(DISC_LATENCY));
                  // Model integrator, sign-extended correction
                  next_rate = model_rate[e.tag] +
                              {{(RATE_WIDTH-DPHI_WIDTH){e.dphi[DPHI_WIDTH-1]}}, e.dphi};
                  model_rate[e.tag] = next_rate;
                  rate_q.push_back('{tag: e.tag, rate: next_rate});
               end
            end else if (disc_q.size() != 0 && cycle > disc_q[0].sent + DISC_LATENCY) begin
               // Strobe never came for the oldest request
               other_errors++;
               $display("Missing disc_valid strobe for channel %0d at time %0t",
                        disc_q[0].tag, $time);
               void'(disc_q.pop_front());
            end
         end
      end
   end

   initial begin : stimulus
      int timeout;
      seed         = 84;
      value_errors = 0;
      other_errors = 0;
      req_valid    = 1'b0;
      req          = '0;
      rst_n        = 1'b0;
      for (int c = 0; c < NUM_CHAN; c++) begin
         model_rate[c] = NOMINAL_RATE;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // Quiet after reset, then a first request on channel 2
      idle_cycles(40);
      send_req(3'd2, 16'd1200, 16'd800);
      idle_cycles(32);

      // Isolated random requests
      repeat (12) begin
         send_req(CHAN_WIDTH'($random(seed)), IQ_WIDTH'($random(seed)),
                  IQ_WIDTH'($random(seed)));
         idle_cycles(30);
      end
      send_req(3'd1, 16'd5000, 16'd5000);
      send_req(3'd3, 16'd200, 16'd4000);
      idle_cycles(30);

      // Truncation corners, tiny values and all zero
      send_req(3'd4, 16'hffff, 16'h0010);
      send_req(3'd5, 16'h0003, 16'hfff0);
      send_req(3'd6, 16'd0, 16'd0);
      send_req(3'd7, 16'd100, 16'd40);
      send_req(3'd0, 16'hffff, 16'hffff);
      send_req(3'd2, 16'd1, 16'd0);
      send_req(3'd1, 16'd0, 16'd7);
      idle_cycles(30);

      // Full-rate burst with random tags
      repeat (200) begin
         send_req(CHAN_WIDTH'($random(seed)), IQ_WIDTH'($random(seed)),
                  IQ_WIDTH'($random(seed)));
      end
      idle_cycles(5);

      // One channel hammered, first back to back then spaced
      repeat (20) begin
         send_req(3'd5, IQ_WIDTH'($random(seed)), IQ_WIDTH'($random(seed)));
      end
      idle_cycles(3);
      repeat (6) begin
         send_req(3'd5, IQ_WIDTH'($random(seed)), IQ_WIDTH'($random(seed)));
         idle_cycles(4);
      end

      // Zero corrections report every channel rate
      for (int c = 0; c < NUM_CHAN; c++) begin
         send_req(CHAN_WIDTH'(c), 16'd900, 16'd900);
      end
      idle_cycles(1);

      // Drain
      timeout = 0;
      while ((disc_q.size() != 0 || rate_q.size() != 0) && timeout < 200) begin
         @(posedge clk);
         timeout++;
      end
      if (timeout >= 200) begin
         other_errors++;
         $display("Timeout: results still pending 200 cycles after the last request");
      end
      idle_cycles(4);

      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* tb.f */
src/dll_pkg.sv
src/dll_operand_norm.sv
src/dll_divider.sv
src/dll_discriminator.sv
src/dll_loop_filter.sv
src/dll_tracker.sv
tb/dll_props.sv
tb/dll_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DLL tracker testbench with Verilator
set -e
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module dll_tb -Mdir obj_dir -f tb.f

status=0
./obj_dir/Vdll_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -qF '** FAIL **' "$LOG" || [ "$status" -ne 0 ]; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
